//--- src.f
+incdir+src
+incdir+tb
src/fp_types_pkg.sv
src/acc_bus_pkg.sv
src/fpss_decode.sv
src/fpss_dispatch.sv
src/fpss_lane.sv
src/fpss_collect.sv
src/fpss_top.sv
tb/tb_fpss.sv

//--- src/acc_bus_pkg.sv
/* Accelerator port types: request, response, the lane issue word and
   the core event strobes */
`include "fpss_consts.svh"

package acc_bus_pkg;
  import fp_types_pkg::*;

  typedef struct packed {
    logic [`FPSS_TAG_W-1:0] id;
    logic [31:0]            data_op;
    logic [`FPSS_FLEN-1:0]  arga;
    logic [`FPSS_FLEN-1:0]  argb;
  } acc_req_t;

  typedef struct packed {
    logic [`FPSS_TAG_W-1:0] id;
    logic [`FPSS_FLEN-1:0]  data;
    logic                   error;
  } acc_resp_t;

  // Decoded instruction handed from the dispatcher to one lane
  typedef struct packed {
    logic [`FPSS_TAG_W-1:0] id;
    fp_op_e                 op;
    fp_fmt_e                fmt;
    logic                   illegal;
    logic [`FPSS_FLEN-1:0]  arga;
    logic [`FPSS_FLEN-1:0]  argb;
  } lane_op_t;

  typedef struct packed {
    logic issue_fpu;
    logic retire_fpu;
  } core_events_t;

endpackage

//--- src/fp_types_pkg.sv
/* Floating-point format types shared by the decoder and the lanes */
package fp_types_pkg;

  // One register word, seen as FP32 or as NaN-boxed FP16
  typedef union packed {
    struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
    } s;
    struct packed {
      logic [15:0] box;
      logic        sign;
      logic [4:0]  exp;
      logic [9:0]  man;
    } h;
  } fp_word_u;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [3:0] {
    SGNJ,
    SGNJN,
    SGNJX,
    MIN,
    MAX,
    FEQ,
    FLT,
    FLE,
    CLASS,
    MVX
  } fp_op_e;

  // FCLASS result, bit 0 is negative infinity
  typedef struct packed {
    logic qnan;
    logic snan;
    logic pos_inf;
    logic pos_norm;
    logic pos_sub;
    logic pos_zero;
    logic neg_zero;
    logic neg_sub;
    logic neg_norm;
    logic neg_inf;
  } fp_class_t;

endpackage

//--- src/fpss_collect.sv
/* Response side. Drains the lanes in the same round-robin order the
   dispatcher fills them, so responses leave in request order. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module fpss_collect (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  acc_bus_pkg::acc_resp_t [`FPSS_NUM_LANES-1:0]  lane_result_i,
  input  logic                   [`FPSS_NUM_LANES-1:0]  lane_valid_i,
  output logic                   [`FPSS_NUM_LANES-1:0]  take_o,
  output acc_bus_pkg::acc_resp_t                        acc_resp_o,
  output logic                                          acc_resp_valid_o,
  input  logic                                          acc_resp_ready_i,
  output logic                                          retire_event_o
);

  localparam int PTR_W = (`FPSS_NUM_LANES > 1) ? $clog2(`FPSS_NUM_LANES) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic             xfer;
  logic             retire_q;

  // Pointed lane straight onto the port
  assign acc_resp_o       = lane_result_i[ptr_q];
  assign acc_resp_valid_o = lane_valid_i[ptr_q];
  assign xfer             = acc_resp_valid_o & acc_resp_ready_i;

  always_comb begin
    take_o        = '0;
    take_o[ptr_q] = xfer;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q    <= '0;
      retire_q <= 1'b0;
    end else begin
      retire_q <= xfer;
      if (xfer) begin
        ptr_q <= (ptr_q == PTR_W'(`FPSS_NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  assign retire_event_o = retire_q;

  resp_stable_when_stalled: assert property (
    @(posedge clk_i) disable iff (reset_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o)
  );

endmodule

//--- src/fpss_consts.svh
/* Shared constants of the FP subsystem: word widths, lane count, OP-FP
   encodings and canonical NaNs. Include wherever one of them is needed. */
`ifndef FPSS_CONSTS_SVH
`define FPSS_CONSTS_SVH

// Datapath and tag widths
`define FPSS_FLEN      32
`define FPSS_NUM_LANES 2
`define FPSS_TAG_W     5

// Major opcode of all kept instructions
`define FPSS_OPC_OP_FP 7'b1010011

// funct7, low two bits select the format (00 single, 10 half)
`define FPSS_F7_SGNJ_S    7'b0010000
`define FPSS_F7_SGNJ_H    7'b0010010
`define FPSS_F7_MINMAX_S  7'b0010100
`define FPSS_F7_MINMAX_H  7'b0010110
`define FPSS_F7_CMP_S     7'b1010000
`define FPSS_F7_CMP_H     7'b1010010
`define FPSS_F7_CLASSMV_S 7'b1110000
`define FPSS_F7_CLASSMV_H 7'b1110010

// Canonical quiet NaNs
`define FPSS_QNAN_S 32'h7fc00000
`define FPSS_QNAN_H 16'h7e00

`endif

//--- src/fpss_decode.sv
/* Instruction decoder. Maps an OP-FP word onto operation and format;
   anything outside the kept set comes out as illegal. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module fpss_decode (
  input  logic                 [31:0] instr_i,
  output fp_types_pkg::fp_op_e        op_o,
  output fp_types_pkg::fp_fmt_e       fmt_o,
  output logic                        illegal_o
);
  import fp_types_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    op_o      = SGNJ;
    fmt_o     = FP32;
    illegal_o = 1'b1;
    if (opcode == `FPSS_OPC_OP_FP) begin
      // Format field sits in funct7[1:0]
      fmt_o = funct7[1] ? FP16 : FP32;
      case (funct7)
        `FPSS_F7_SGNJ_S, `FPSS_F7_SGNJ_H: begin
          illegal_o = 1'b0;
          case (funct3)
            3'b000:  op_o = SGNJ;
            3'b001:  op_o = SGNJN;
            3'b010:  op_o = SGNJX;
            default: illegal_o = 1'b1;
          endcase
        end
        `FPSS_F7_MINMAX_S, `FPSS_F7_MINMAX_H: begin
          illegal_o = 1'b0;
          case (funct3)
            3'b000:  op_o = MIN;
            3'b001:  op_o = MAX;
            default: illegal_o = 1'b1;
          endcase
        end
        `FPSS_F7_CMP_S, `FPSS_F7_CMP_H: begin
          illegal_o = 1'b0;
          case (funct3)
            3'b010:  op_o = FEQ;
            3'b001:  op_o = FLT;
            3'b000:  op_o = FLE;
            default: illegal_o = 1'b1;
          endcase
        end
        `FPSS_F7_CLASSMV_S, `FPSS_F7_CLASSMV_H: begin
          // Unary ops, rs2 must be zero
          illegal_o = (rs2 != 5'd0);
          case (funct3)
            3'b000:  op_o = MVX;
            3'b001:  op_o = CLASS;
            default: illegal_o = 1'b1;
          endcase
        end
        default: illegal_o = 1'b1;
      endcase
    end
  end

endmodule

//--- src/fpss_dispatch.sv
/* Request side: one input register, decode, and round-robin issue to the
   execution lanes. Back-pressures the core while the pointed lane is busy. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module fpss_dispatch (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  acc_bus_pkg::acc_req_t                 acc_req_i,
  input  logic                                  acc_req_valid_i,
  output logic                                  acc_req_ready_o,
  output acc_bus_pkg::lane_op_t                 lane_op_o,
  output logic             [`FPSS_NUM_LANES-1:0] issue_valid_o,
  input  logic             [`FPSS_NUM_LANES-1:0] lane_ready_i,
  output logic                                  issue_event_o
);
  import fp_types_pkg::*;
  import acc_bus_pkg::*;

  localparam int PTR_W = (`FPSS_NUM_LANES > 1) ? $clog2(`FPSS_NUM_LANES) : 1;

  acc_req_t   req_q;
  logic       full_q;
  logic [PTR_W-1:0] ptr_q;
  fp_op_e     dec_op;
  fp_fmt_e    dec_fmt;
  logic       dec_illegal;
  logic       issue;
  logic       issue_q;

  fpss_decode i_decode (
    .instr_i   ( req_q.data_op ),
    .op_o      ( dec_op        ),
    .fmt_o     ( dec_fmt       ),
    .illegal_o ( dec_illegal   )
  );

  // ----------------------------------------
  // Issue to the pointed lane
  // ----------------------------------------
  assign issue           = full_q & lane_ready_i[ptr_q];
  assign acc_req_ready_o = ~full_q | issue;

  always_comb begin
    issue_valid_o        = '0;
    issue_valid_o[ptr_q] = issue;
  end

  assign lane_op_o = '{
    id:      req_q.id,
    op:      dec_op,
    fmt:     dec_fmt,
    illegal: dec_illegal,
    arga:    req_q.arga,
    argb:    req_q.argb
  };

  // Input register
  always_ff @(posedge clk_i) begin
    if (acc_req_valid_i && acc_req_ready_o) begin
      req_q <= acc_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_q  <= 1'b0;
      ptr_q   <= '0;
      issue_q <= 1'b0;
    end else begin
      issue_q <= issue;
      if (acc_req_ready_o) begin
        full_q <= acc_req_valid_i;
      end
      if (issue) begin
        ptr_q <= (ptr_q == PTR_W'(`FPSS_NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end
    end
  end

  assign issue_event_o = issue_q;

  // Core side holds a stalled request steady until it is taken
  req_held_while_stalled: assert property (
    @(posedge clk_i) disable iff (reset_i)
    acc_req_valid_i && !acc_req_ready_o |=> acc_req_valid_i && $stable(acc_req_i)
  );

endmodule

//--- src/fpss_lane.sv
/* One execution lane. Computes sign injection, min/max, compare, class and
   move results in a single cycle and holds the result until it is drained. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module fpss_lane (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  acc_bus_pkg::lane_op_t  lane_op_i,
  input  logic                   issue_i,
  output logic                   ready_o,
  output acc_bus_pkg::acc_resp_t result_o,
  output logic                   valid_o,
  input  logic                   take_i
);
  import fp_types_pkg::*;
  import acc_bus_pkg::*;

  // Format-independent view of one operand
  typedef struct packed {
    logic        sgn;
    logic        exp_zero;
    logic        exp_ones;
    logic        man_zero;
    logic        quiet;
    logic [30:0] mag;
  } opnd_t;

  localparam logic [31:0] QNAN_H_BOXED = {16'hffff, `FPSS_QNAN_H};

  // Unboxed half operands read as the canonical NaN
  function automatic fp_word_u box_fix(input logic [31:0] w, input fp_fmt_e fmt);
    fp_word_u u;
    u = w;
    if (fmt == FP16 && u.h.box != 16'hffff) begin
      u = QNAN_H_BOXED;
    end
    return u;
  endfunction

  function automatic opnd_t unpack(input fp_word_u u, input fp_fmt_e fmt);
    opnd_t o;
    if (fmt == FP32) begin
      o.sgn      = u.s.sign;
      o.exp_zero = (u.s.exp == '0);
      o.exp_ones = &u.s.exp;
      o.man_zero = (u.s.man == '0);
      o.quiet    = u.s.man[22];
      o.mag      = {u.s.exp, u.s.man};
    end else begin
      o.sgn      = u.h.sign;
      o.exp_zero = (u.h.exp == '0);
      o.exp_ones = &u.h.exp;
      o.man_zero = (u.h.man == '0);
      o.quiet    = u.h.man[9];
      o.mag      = {16'b0, u.h.exp, u.h.man};
    end
    return o;
  endfunction

  fp_fmt_e     fmt;
  fp_word_u    a_w;
  fp_word_u    b_w;
  opnd_t       a;
  opnd_t       b;
  logic        a_nan;
  logic        b_nan;
  logic        both_zero;
  logic        lt_tot;
  logic        feq;
  logic        flt;
  logic        fle;
  logic        res_sgn;
  logic [31:0] qnan_w;
  logic [31:0] sgnj_res;
  logic [31:0] minmax_res;
  logic [31:0] mvx_res;
  fp_class_t   cls;
  acc_resp_t   result_d;
  acc_resp_t   result_q;
  logic        valid_q;

  assign fmt = lane_op_i.fmt;
  assign a_w = box_fix(lane_op_i.arga, fmt);
  assign b_w = box_fix(lane_op_i.argb, fmt);
  assign a   = unpack(a_w, fmt);
  assign b   = unpack(b_w, fmt);

  assign a_nan     = a.exp_ones & ~a.man_zero;
  assign b_nan     = b.exp_ones & ~b.man_zero;
  assign both_zero = (a.mag == '0) && (b.mag == '0);
  assign qnan_w    = (fmt == FP32) ? `FPSS_QNAN_S : QNAN_H_BOXED;

  // Total order on non-NaN values, -0 below +0
  always_comb begin
    if (a.sgn != b.sgn) begin
      lt_tot = a.sgn;
    end else if (a.sgn) begin
      lt_tot = a.mag > b.mag;
    end else begin
      lt_tot = a.mag < b.mag;
    end
  end

  // ----------------------------------------
  // Compare, min/max
  // ----------------------------------------
  assign feq = ~a_nan & ~b_nan & (((a.mag == b.mag) & (a.sgn == b.sgn)) | both_zero);
  assign flt = ~a_nan & ~b_nan & lt_tot & ~both_zero;
  assign fle = flt | feq;

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = qnan_w;
    end else if (a_nan) begin
      minmax_res = b_w;
    end else if (b_nan) begin
      minmax_res = a_w;
    end else if (lane_op_i.op == MIN) begin
      minmax_res = lt_tot ? a_w : b_w;
    end else begin
      minmax_res = lt_tot ? b_w : a_w;
    end
  end

  // ----------------------------------------
  // Sign injection, class, move
  // ----------------------------------------
  always_comb begin
    case (lane_op_i.op)
      SGNJ:    res_sgn = b.sgn;
      SGNJN:   res_sgn = ~b.sgn;
      default: res_sgn = a.sgn ^ b.sgn;
    endcase
  end

  assign sgnj_res = (fmt == FP32) ? {res_sgn, a_w.s.exp, a_w.s.man}
                                  : {16'hffff, res_sgn, a_w.h.exp, a_w.h.man};

  assign cls.qnan     = a_nan & a.quiet;
  assign cls.snan     = a_nan & ~a.quiet;
  assign cls.pos_inf  = ~a.sgn & a.exp_ones & a.man_zero;
  assign cls.pos_norm = ~a.sgn & ~a.exp_zero & ~a.exp_ones;
  assign cls.pos_sub  = ~a.sgn & a.exp_zero & ~a.man_zero;
  assign cls.pos_zero = ~a.sgn & a.exp_zero & a.man_zero;
  assign cls.neg_zero = a.sgn & a.exp_zero & a.man_zero;
  assign cls.neg_sub  = a.sgn & a.exp_zero & ~a.man_zero;
  assign cls.neg_norm = a.sgn & ~a.exp_zero & ~a.exp_ones;
  assign cls.neg_inf  = a.sgn & a.exp_ones & a.man_zero;

  // Raw bit move, no NaN-box check
  assign mvx_res = (fmt == FP32) ? lane_op_i.arga
                                 : {{16{lane_op_i.arga[15]}}, lane_op_i.arga[15:0]};

  always_comb begin
    result_d.id    = lane_op_i.id;
    result_d.data  = '0;
    result_d.error = 1'b0;
    if (lane_op_i.illegal) begin
      result_d.error = 1'b1;
    end else begin
      case (lane_op_i.op)
        SGNJ, SGNJN, SGNJX: result_d.data = sgnj_res;
        MIN, MAX:           result_d.data = minmax_res;
        FEQ:                result_d.data = {31'b0, feq};
        FLT:                result_d.data = {31'b0, flt};
        FLE:                result_d.data = {31'b0, fle};
        CLASS:              result_d.data = {22'b0, cls};
        MVX:                result_d.data = mvx_res;
        default:            result_d.error = 1'b1;
      endcase
    end
  end

  // Result holding register
  always_ff @(posedge clk_i) begin
    if (issue_i) begin
      result_q <= result_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (issue_i) begin
      valid_q <= 1'b1;
    end else if (take_i) begin
      valid_q <= 1'b0;
    end
  end

  assign ready_o  = ~valid_q;
  assign valid_o  = valid_q;
  assign result_o = result_q;

  no_issue_while_full: assert property (
    @(posedge clk_i) disable iff (reset_i)
    issue_i |-> !valid_q
  );

endmodule

//--- src/fpss_top.sv
/* Top level of the FP subsystem on the accelerator port: dispatcher,
   NUM_LANES execution lanes and the in-order collector. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module fpss_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  acc_bus_pkg::acc_req_t      acc_req_i,
  input  logic                       acc_req_valid_i,
  output logic                       acc_req_ready_o,
  output acc_bus_pkg::acc_resp_t     acc_resp_o,
  output logic                       acc_resp_valid_o,
  input  logic                       acc_resp_ready_i,
  output acc_bus_pkg::core_events_t  core_events_o
);
  import acc_bus_pkg::*;

  lane_op_t                         lane_op;
  logic      [`FPSS_NUM_LANES-1:0]  issue_valid;
  logic      [`FPSS_NUM_LANES-1:0]  lane_ready;
  acc_resp_t [`FPSS_NUM_LANES-1:0]  lane_result;
  logic      [`FPSS_NUM_LANES-1:0]  lane_valid;
  logic      [`FPSS_NUM_LANES-1:0]  lane_take;

  fpss_dispatch i_dispatch (
    .clk_i,
    .reset_i,
    .acc_req_i,
    .acc_req_valid_i,
    .acc_req_ready_o,
    .lane_op_o     ( lane_op                 ),
    .issue_valid_o ( issue_valid             ),
    .lane_ready_i  ( lane_ready              ),
    .issue_event_o ( core_events_o.issue_fpu )
  );

  // Identical lanes share the issue word, selected by their valid bit
  for (genvar i = 0; i < `FPSS_NUM_LANES; i++) begin : gen_lanes
    fpss_lane i_lane (
      .clk_i,
      .reset_i,
      .lane_op_i ( lane_op        ),
      .issue_i   ( issue_valid[i] ),
      .ready_o   ( lane_ready[i]  ),
      .result_o  ( lane_result[i] ),
      .valid_o   ( lane_valid[i]  ),
      .take_i    ( lane_take[i]   )
    );
  end

  fpss_collect i_collect (
    .clk_i,
    .reset_i,
    .lane_result_i  ( lane_result              ),
    .lane_valid_i   ( lane_valid               ),
    .take_o         ( lane_take                ),
    .acc_resp_o,
    .acc_resp_valid_o,
    .acc_resp_ready_i,
    .retire_event_o ( core_events_o.retire_fpu )
  );

endmodule

//--- tb/tb_fpss_vectors.svh
/* Test table for the FP subsystem testbench, included into its module body.
   Each row holds name, instruction, arga, argb, expected data and expected error. */

task automatic load_table();
  // Sign injection, single and half
  add_vec("fsgnj_s",          32'h20000053, 32'h3f800000, 32'hc0000000, 32'hbf800000, 1'b0);
  add_vec("fsgnjn_s",         32'h20001053, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0);
  add_vec("fsgnjx_s",         32'h20002053, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0);
  add_vec("fsgnj_h",          32'h24000053, 32'hffff3c00, 32'hffffc000, 32'hffffbc00, 1'b0);
  add_vec("fsgnjn_h",         32'h24001053, 32'hffff3c00, 32'hffff4000, 32'hffffbc00, 1'b0);
  add_vec("fsgnjx_h",         32'h24002053, 32'hffffbc00, 32'hffffc000, 32'hffff3c00, 1'b0);
  add_vec("fsgnj_h_unboxed",  32'h24000053, 32'h00003c00, 32'hffffc000, 32'hfffffe00, 1'b0);
  // Min and max
  add_vec("fmin_s_zero",      32'h28000053, 32'h00000000, 32'h80000000, 32'h80000000, 1'b0);
  add_vec("fmax_s_zero",      32'h28001053, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
  add_vec("fmin_s_one_nan",   32'h28000053, 32'h7fc00000, 32'h40000000, 32'h40000000, 1'b0);
  add_vec("fmax_s_two_nan",   32'h28001053, 32'h7f800001, 32'hffc00000, 32'h7fc00000, 1'b0);
  add_vec("fmin_h",           32'h2c000053, 32'hffff4000, 32'hffffbc00, 32'hffffbc00, 1'b0);
  add_vec("fmax_h_unboxed",   32'h2c001053, 32'h00004000, 32'hffff3c00, 32'hffff3c00, 1'b0);
  add_vec("fmin_h_two_nan",   32'h2c000053, 32'hffff7c01, 32'h00000000, 32'hffff7e00, 1'b0);
  // FADD is not part of the kept set
  add_vec("illegal_fadd_s",   32'h00000053, 32'h3f800000, 32'h3f800000, 32'h00000000, 1'b1);
  // Compares
  add_vec("feq_s_zeros",      32'ha0002053, 32'h00000000, 32'h80000000, 32'h00000001, 1'b0);
  add_vec("flt_s_neg",        32'ha0001053, 32'hc0000000, 32'hbf800000, 32'h00000001, 1'b0);
  add_vec("fle_h",            32'ha4000053, 32'hffff3c00, 32'hffff3c00, 32'h00000001, 1'b0);
  add_vec("flt_s_nan",        32'ha0001053, 32'h3f800000, 32'h7fc00000, 32'h00000000, 1'b0);
  add_vec("feq_s_nan",        32'ha0002053, 32'h7fc00000, 32'h7fc00000, 32'h00000000, 1'b0);
  add_vec("fle_h_unboxed",    32'ha4000053, 32'hffff3c00, 32'h00003c00, 32'h00000000, 1'b0);
  // One vector per FCLASS class, negative infinity in bit 0
  add_vec("fclass_s_neg_inf", 32'he0001053, 32'hff800000, 32'h00000000, 32'h00000001, 1'b0);
  add_vec("fclass_s_neg_nrm", 32'he0001053, 32'hbf800000, 32'h00000000, 32'h00000002, 1'b0);
  add_vec("fclass_h_neg_sub", 32'he4001053, 32'hffff8001, 32'h00000000, 32'h00000004, 1'b0);
  add_vec("fclass_s_neg_zro", 32'he0001053, 32'h80000000, 32'h00000000, 32'h00000008, 1'b0);
  add_vec("fclass_h_pos_zro", 32'he4001053, 32'hffff0000, 32'h00000000, 32'h00000010, 1'b0);
  add_vec("fclass_s_pos_sub", 32'he0001053, 32'h00000001, 32'h00000000, 32'h00000020, 1'b0);
  add_vec("fclass_h_pos_nrm", 32'he4001053, 32'hffff3c00, 32'h00000000, 32'h00000040, 1'b0);
  add_vec("fclass_s_pos_inf", 32'he0001053, 32'h7f800000, 32'h00000000, 32'h00000080, 1'b0);
  add_vec("fclass_s_snan",    32'he0001053, 32'h7f800001, 32'h00000000, 32'h00000100, 1'b0);
  add_vec("fclass_h_qnan",    32'he4001053, 32'hffff7e00, 32'h00000000, 32'h00000200, 1'b0);
  // Unary op with rs2 set
  add_vec("fclass_s_bad_rs2", 32'he0101053, 32'h3f800000, 32'h00000000, 32'h00000000, 1'b1);
  // Moves
  add_vec("fmv_x_w",          32'he0000053, 32'h12345678, 32'h00000000, 32'h12345678, 1'b0);
  add_vec("fmv_x_h",          32'he4000053, 32'h0000c123, 32'h00000000, 32'hffffc123, 1'b0);
endtask

//--- tb/tb_fpss.sv
/* Testbench for the FP subsystem. Streams the vector table through the
   accelerator port under random response back-pressure and checks results in order. */
`timescale 1ns/100ps
`include "fpss_consts.svh"

module tb_fpss;
  import acc_bus_pkg::*;

  typedef struct packed {
    logic [31:0]           instr;
    logic [`FPSS_FLEN-1:0] arga;
    logic [`FPSS_FLEN-1:0] argb;
    logic [`FPSS_FLEN-1:0] data;
    logic                  error;
  } vec_t;

  logic         clk_i;
  logic         reset_i;
  acc_req_t     acc_req_i;
  logic         acc_req_valid_i;
  logic         acc_req_ready_o;
  acc_resp_t    acc_resp_o;
  logic         acc_resp_valid_o;
  logic         acc_resp_ready_i;
  core_events_t core_events_o;

  vec_t   vecs[$];
  string  names[$];
  integer seed = 32'hced25cbd;
  int     cycles = 0;
  int     limit = 0;
  int     rx_count = 0;
  int     pass_count = 0;
  int     fail_count = 0;
  int     issue_count = 0;
  int     retire_count = 0;

  fpss_top uut (
    .clk_i,
    .reset_i,
    .acc_req_i,
    .acc_req_valid_i,
    .acc_req_ready_o,
    .acc_resp_o,
    .acc_resp_valid_o,
    .acc_resp_ready_i,
    .core_events_o
  );

  always #4 clk_i = ~clk_i;

  `include "tb_fpss_vectors.svh"

  task automatic add_vec(input string name, input logic [31:0] instr,
                         input logic [31:0] arga, input logic [31:0] argb,
                         input logic [31:0] data, input logic error);
    vec_t v;
    v.instr = instr;
    v.arga  = arga;
    v.argb  = argb;
    v.data  = data;
    v.error = error;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic check_data(input string name, input logic [`FPSS_FLEN-1:0] exp_v,
                            input logic [`FPSS_FLEN-1:0] act_v, inout bit ok);
    if (act_v !== exp_v) begin
      $display("ERROR %0s: data expected %h, got %h", name, exp_v, act_v);
      ok = 1'b0;
    end
  endtask

  task automatic check_error(input string name, input logic exp_v, input logic act_v,
                             inout bit ok);
    if (act_v !== exp_v) begin
      $display("ERROR %0s: error flag expected %b, got %b", name, exp_v, act_v);
      ok = 1'b0;
    end
  endtask

  task automatic check_id(input string name, input logic [`FPSS_TAG_W-1:0] exp_v,
                          input logic [`FPSS_TAG_W-1:0] act_v, inout bit ok);
    if (act_v !== exp_v) begin
      $display("ERROR %0s: id expected %0d, got %0d", name, exp_v, act_v);
      ok = 1'b0;
    end
  endtask

  // ----------------------------------------
  // Request driver and response checker
  // ----------------------------------------
  task automatic drive_requests();
    for (int i = 0; i < vecs.size(); i++) begin
      acc_req_i = '{
        id:      i[`FPSS_TAG_W-1:0],
        data_op: vecs[i].instr,
        arga:    vecs[i].arga,
        argb:    vecs[i].argb
      };
      acc_req_valid_i = 1'b1;
      // Ready only moves on the rising edge, so the falling edge sees it settled
      @(negedge clk_i);
      while (!acc_req_ready_o) begin
        @(negedge clk_i);
      end
      @(posedge clk_i);
      #1;
    end
    acc_req_valid_i = 1'b0;
  endtask

  task automatic collect_responses();
    bit ok;
    while (rx_count < vecs.size()) begin
      @(posedge clk_i);
      #1 acc_resp_ready_i = $random(seed) & 1;
      @(negedge clk_i);
      if (acc_resp_valid_o && acc_resp_ready_i) begin
        ok = 1'b1;
        check_id(names[rx_count], rx_count[`FPSS_TAG_W-1:0], acc_resp_o.id, ok);
        check_data(names[rx_count], vecs[rx_count].data, acc_resp_o.data, ok);
        check_error(names[rx_count], vecs[rx_count].error, acc_resp_o.error, ok);
        if (ok) begin
          pass_count++;
          $display("PASS %0s", names[rx_count]);
        end else begin
          fail_count++;
        end
        rx_count++;
      end
    end
    @(posedge clk_i);
    #1 acc_resp_ready_i = 1'b0;
  endtask

  // Event strobes are registered, sample them away from the rising edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (core_events_o.issue_fpu) begin
        issue_count++;
      end
      if (core_events_o.retire_fpu) begin
        retire_count++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= limit) begin
      $display("Timeout after %0d cycles, only %0d of %0d responses arrived",
               cycles, rx_count, vecs.size());
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    acc_req_i        = '0;
    acc_req_valid_i  = 1'b0;
    acc_resp_ready_i = 1'b0;
    load_table();
    limit = vecs.size() * (`FPSS_NUM_LANES + 6) + 100;

    repeat (2) @(posedge clk_i);
    #1 reset_i = 1'b0;

    fork
      drive_requests();
      collect_responses();
    join

    // Let the last retire strobe land
    repeat (3) @(posedge clk_i);
    if (issue_count != vecs.size() || retire_count != vecs.size()) begin
      $display("ERROR events: expected %0d issue and retire strobes, got %0d and %0d",
               vecs.size(), issue_count, retire_count);
      fail_count++;
    end else begin
      pass_count++;
      $display("PASS events");
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
